// ==== logic/branch_history.sv ====
// branch history table
// 2-bit saturating counters indexed by pc, trained by resolved branches
module branch_history import fetch_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic [ADDR_W-1:0] pc_i,
    output logic              taken_o,
    output logic              valid_o,
    input  resolved_t         resolved_i
);

    logic [1:0]             ctr_q [BHT_ENTRIES];
    logic [BHT_ENTRIES-1:0] valid_q;
    logic [BHT_IDX_W-1:0]   rd_idx;
    logic [BHT_IDX_W-1:0]   wr_idx;
    logic [1:0]             ctr_old;
    logic [1:0]             ctr_new;

    // word aligned pc, skip bits 1:0
    assign rd_idx  = pc_i[BHT_IDX_W+1:2];
    assign wr_idx  = resolved_i.pc[BHT_IDX_W+1:2];

    // msb set means 2 or 3, weakly or strongly taken
    assign taken_o = ctr_q[rd_idx][1];
    assign valid_o = valid_q[rd_idx];

    // --------------------------------------------------
    // counter update
    // --------------------------------------------------
    assign ctr_old = ctr_q[wr_idx];

    always_comb begin
        if (!valid_q[wr_idx]) begin
            // fresh entry starts weak in the resolved direction
            ctr_new = resolved_i.is_taken ? 2'b10 : 2'b01;
        end else if (resolved_i.is_taken) begin
            ctr_new = (ctr_old == 2'b11) ? 2'b11 : ctr_old + 2'b01;
        end else begin
            ctr_new = (ctr_old == 2'b00) ? 2'b00 : ctr_old - 2'b01;
        end
    end

    always_ff @(posedge clk_i) begin
        if (resolved_i.valid) begin
            ctr_q[wr_idx] <= ctr_new;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (resolved_i.valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

endmodule

// ==== logic/branch_predict.sv ====
// branch prediction
// filters stale cache responses, predicts the next pc and builds the queue entry
module branch_predict import fetch_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  icache_rsp_t  icache_rsp_i,
    input  logic         kill_i,
    input  logic         ext_redirect_i,
    input  resolved_t    resolved_i,
    output predict_t     predict_o,
    output logic         push_o,
    output fetch_entry_t entry_o
);

    // response to a killed request arrives now
    logic              stale_q;
    logic              accept;
    scan_t             scan;
    logic              bht_taken;
    logic              bht_valid;
    logic [ADDR_W-1:0] ras_top;
    logic              ras_valid;
    logic              ras_push;
    logic              ras_pop;
    logic [ADDR_W-1:0] link_addr;

    assign accept    = icache_rsp_i.valid & ~stale_q & ~ext_redirect_i;
    assign link_addr = icache_rsp_i.vaddr + ADDR_W'(4);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stale_q <= 1'b0;
        end else begin
            stale_q <= kill_i;
        end
    end

    instr_scan i_instr_scan (
        .instr_i ( icache_rsp_i.data ),
        .scan_o  ( scan              )
    );

    branch_history i_branch_history (
        .clk_i      ( clk_i              ),
        .rst_ni     ( rst_ni             ),
        .pc_i       ( icache_rsp_i.vaddr ),
        .taken_o    ( bht_taken          ),
        .valid_o    ( bht_valid          ),
        .resolved_i ( resolved_i         )
    );

    return_stack i_return_stack (
        .clk_i   ( clk_i     ),
        .rst_ni  ( rst_ni    ),
        .push_i  ( ras_push  ),
        .pop_i   ( ras_pop   ),
        .data_i  ( link_addr ),
        .top_o   ( ras_top   ),
        .valid_o ( ras_valid )
    );

    // --------------------------------------------------
    // prediction
    // --------------------------------------------------
    always_comb begin
        predict_o = '0;
        ras_push  = 1'b0;
        ras_pop   = 1'b0;
        if (accept) begin
            unique case (scan.cf)
                // dynamic if trained, else backward taken
                Branch: begin
                    predict_o.taken  = bht_valid ? bht_taken : scan.imm[ADDR_W-1];
                    predict_o.target = icache_rsp_i.vaddr + scan.imm;
                end
                Jump: begin
                    predict_o.taken  = 1'b1;
                    predict_o.target = icache_rsp_i.vaddr + scan.imm;
                end
                Call: begin
                    predict_o.taken  = 1'b1;
                    predict_o.target = icache_rsp_i.vaddr + scan.imm;
                    ras_push         = 1'b1;
                end
                // empty stack, let it fall through
                Return: begin
                    if (ras_valid) begin
                        predict_o.taken  = 1'b1;
                        predict_o.target = ras_top;
                        ras_pop          = 1'b1;
                    end
                end
                default: begin
                    predict_o.taken = 1'b0;
                end
            endcase
        end
    end

    // queue entry carries the predicted next pc either way
    assign push_o                  = accept;
    assign entry_o.addr            = icache_rsp_i.vaddr;
    assign entry_o.instr           = icache_rsp_i.data;
    assign entry_o.taken           = predict_o.taken;
    assign entry_o.predict_address = predict_o.taken ? predict_o.target : link_addr;

endmodule

// ==== logic/fetch_frontend.sv ====
// instruction fetch frontend
// pc generation, branch prediction and the fetch queue toward decode
module fetch_frontend import fetch_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic [ADDR_W-1:0] boot_addr_i,
    input  resolved_t         resolved_i,
    input  redirect_t         redirect_i,
    output icache_req_t       icache_req_o,
    input  icache_rsp_t       icache_rsp_i,
    output fetch_entry_t      fetch_entry_o,
    output logic              fetch_valid_o,
    input  logic              fetch_ack_i
);

    predict_t     predict;
    fetch_entry_t entry;
    logic         push;
    logic         can_fetch;
    logic         ext_redirect;
    // response dropped and queue cleared
    logic         drop;

    assign drop = ext_redirect | flush_i;

    pc_select i_pc_select (
        .clk_i          ( clk_i        ),
        .rst_ni         ( rst_ni       ),
        .boot_addr_i    ( boot_addr_i  ),
        .can_fetch_i    ( can_fetch    ),
        .predict_i      ( predict      ),
        .resolved_i     ( resolved_i   ),
        .redirect_i     ( redirect_i   ),
        .flush_i        ( flush_i      ),
        .icache_req_o   ( icache_req_o ),
        .ext_redirect_o ( ext_redirect )
    );

    branch_predict i_branch_predict (
        .clk_i          ( clk_i             ),
        .rst_ni         ( rst_ni            ),
        .icache_rsp_i   ( icache_rsp_i      ),
        .kill_i         ( icache_req_o.kill ),
        .ext_redirect_i ( drop              ),
        .resolved_i     ( resolved_i        ),
        .predict_o      ( predict           ),
        .push_o         ( push              ),
        .entry_o        ( entry             )
    );

    fetch_queue i_fetch_queue (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_i       ( drop          ),
        .push_i        ( push          ),
        .entry_i       ( entry         ),
        .fetch_entry_o ( fetch_entry_o ),
        .fetch_valid_o ( fetch_valid_o ),
        .fetch_ack_i   ( fetch_ack_i   ),
        .can_fetch_o   ( can_fetch     )
    );

endmodule

// ==== logic/fetch_pkg.sv ====
// fetch frontend package
// widths, RV32I opcodes, table sizes and the structs shared by the frontend
package fetch_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam int ADDR_W      = 32;
    localparam int INSTR_W     = 32;
    localparam int BHT_ENTRIES = 16;
    localparam int RAS_DEPTH   = 4;
    localparam int QUEUE_DEPTH = 4;

    // derived index and count widths
    localparam int BHT_IDX_W   = $clog2(BHT_ENTRIES);
    localparam int RAS_CNT_W   = $clog2(RAS_DEPTH + 1);
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // RV32I control flow opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    // x1, the link register
    localparam logic [4:0] REG_RA     = 5'd1;

    // --------------------------------------------------
    // types
    // --------------------------------------------------
    typedef enum logic [3:0] {
        None,
        Branch,
        Jump,
        Call,
        Return
    } cf_e;

    typedef struct packed {
        logic              req;
        logic              kill;
        logic [ADDR_W-1:0] vaddr;
    } icache_req_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] vaddr;
        logic [ADDR_W-1:0] data;
    } icache_rsp_t;

    // branch outcome from execute, target is the correct next pc
    typedef struct packed {
        logic              valid;
        logic              is_mispredict;
        logic              is_taken;
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] target;
    } resolved_t;

    // commit and csr side pc changes
    typedef struct packed {
        logic              ex_valid;
        logic [ADDR_W-1:0] trap_vector;
        logic              eret;
        logic [ADDR_W-1:0] epc;
        logic              set_pc_commit;
        logic [ADDR_W-1:0] pc_commit;
    } redirect_t;

    typedef struct packed {
        cf_e               cf;
        logic [ADDR_W-1:0] imm;
    } scan_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [INSTR_W-1:0] instr;
        logic               taken;
        logic [ADDR_W-1:0]  predict_address;
    } fetch_entry_t;

    typedef struct packed {
        logic              taken;
        logic [ADDR_W-1:0] target;
    } predict_t;

endpackage

// ==== logic/fetch_queue.sv ====
// fetch queue
// circular buffer of fetched words toward decode, gates new cache requests
module fetch_queue import fetch_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    input  logic         push_i,
    input  fetch_entry_t entry_i,
    output fetch_entry_t fetch_entry_o,
    output logic         fetch_valid_o,
    input  logic         fetch_ack_i,
    output logic         can_fetch_o
);

    fetch_entry_t           mem_q [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [QUEUE_CNT_W-1:0] count_q;
    logic                   pop;

    assign fetch_valid_o = (count_q != '0);
    assign fetch_entry_o = mem_q[rd_ptr_q];
    assign pop           = fetch_valid_o & fetch_ack_i;

    // keep one slot free for the word still in flight
    assign can_fetch_o   = (count_q <= QUEUE_CNT_W'(QUEUE_DEPTH - 2));

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // push and pop together leave the count alone
            if (push_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // the request gate upstream must keep room for every response
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i && !flush_i |-> count_q < QUEUE_CNT_W'(QUEUE_DEPTH))
        else $error("fetch queue overflow");

endmodule

// ==== logic/instr_scan.sv ====
// instruction scan
// classifies one RV32I word by control flow and extracts its immediate
module instr_scan import fetch_pkg::*; (
    input  logic [INSTR_W-1:0] instr_i,
    output scan_t              scan_o
);

    logic [6:0]        opcode;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [ADDR_W-1:0] imm_b;
    logic [ADDR_W-1:0] imm_j;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];

    // B-type, sign extended, bit 0 always zero
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    // J-type, sign extended
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        scan_o.cf  = None;
        scan_o.imm = '0;
        unique case (opcode)
            OPC_BRANCH: begin
                scan_o.cf  = Branch;
                scan_o.imm = imm_b;
            end
            // jal that links through ra is a call
            OPC_JAL: begin
                scan_o.cf  = (rd == REG_RA) ? Call : Jump;
                scan_o.imm = imm_j;
            end
            // only "jalr x0, 0(ra)" is recognized, other jalr fall through
            OPC_JALR: begin
                if (rd == 5'd0 && rs1 == REG_RA) begin
                    scan_o.cf = Return;
                end
            end
            default: begin
                scan_o.cf = None;
            end
        endcase
    end

endmodule

// ==== logic/pc_select.sv ====
// next pc generation
// holds the fetch pc, picks the next one by priority and drives the cache request
module pc_select import fetch_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic [ADDR_W-1:0] boot_addr_i,
    input  logic              can_fetch_i,
    input  predict_t          predict_i,
    input  resolved_t         resolved_i,
    input  redirect_t         redirect_i,
    input  logic              flush_i,
    output icache_req_t       icache_req_o,
    output logic              ext_redirect_o
);

    logic [ADDR_W-1:0] npc_d;
    logic [ADDR_W-1:0] npc_q;
    // set out of reset, the first cycle loads the boot address
    logic              boot_q;
    logic              mispredict;

    assign mispredict     = resolved_i.valid & resolved_i.is_mispredict;
    // any redirect coming from behind the frontend
    assign ext_redirect_o = mispredict | redirect_i.ex_valid | redirect_i.eret
                          | redirect_i.set_pc_commit;

    // --------------------------------------------------
    // cache request
    // --------------------------------------------------
    // only request when the queue has room for the in-flight word
    assign icache_req_o.req   = ~boot_q & can_fetch_i;
    // kill the word in flight on any change of flow
    assign icache_req_o.kill  = ~boot_q & (predict_i.taken | ext_redirect_o | flush_i);
    assign icache_req_o.vaddr = npc_q;

    // --------------------------------------------------
    // next pc, lowest priority first
    // --------------------------------------------------
    always_comb begin
        // hold by default
        npc_d = npc_q;
        if (boot_q) begin
            npc_d = boot_addr_i;
        end
        // sequential step, a flush keeps the pc so the word is fetched again
        if (icache_req_o.req && !flush_i) begin
            npc_d = npc_q + ADDR_W'(4);
        end
        if (predict_i.taken) begin
            npc_d = predict_i.target;
        end
        if (mispredict) begin
            npc_d = resolved_i.target;
        end
        if (redirect_i.eret) begin
            npc_d = redirect_i.epc;
        end
        if (redirect_i.ex_valid) begin
            npc_d = redirect_i.trap_vector;
        end
        // restart after the instruction in commit
        if (redirect_i.set_pc_commit) begin
            npc_d = redirect_i.pc_commit + ADDR_W'(4);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            boot_q <= 1'b1;
            npc_q  <= '0;
        end else begin
            boot_q <= 1'b0;
            npc_q  <= npc_d;
        end
    end

    // targets from the predictor and the backend must stay word aligned
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        icache_req_o.req |-> icache_req_o.vaddr[1:0] == 2'b00)
        else $error("unaligned fetch address %h", icache_req_o.vaddr);

endmodule

// ==== logic/return_stack.sv ====
// return address stack
// shift register stack, a push when full drops the oldest address
module return_stack import fetch_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              push_i,
    input  logic              pop_i,
    input  logic [ADDR_W-1:0] data_i,
    output logic [ADDR_W-1:0] top_o,
    output logic              valid_o
);

    // entry 0 is the top
    logic [ADDR_W-1:0]    stack_q [RAS_DEPTH];
    logic [RAS_CNT_W-1:0] count_q;

    assign top_o   = stack_q[0];
    assign valid_o = (count_q != '0);

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            stack_q[0] <= data_i;
            for (int i = 1; i < RAS_DEPTH; i++) begin
                stack_q[i] <= stack_q[i-1];
            end
        end else if (pop_i) begin
            for (int i = 0; i < RAS_DEPTH - 1; i++) begin
                stack_q[i] <= stack_q[i+1];
            end
        end
    end

    // count saturates at depth, pop on empty is ignored
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (push_i && count_q != RAS_CNT_W'(RAS_DEPTH)) begin
            count_q <= count_q + 1'b1;
        end else if (pop_i && count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // a scanned word is either a call or a return, never both
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && pop_i))
        else $error("return stack push and pop in the same cycle");

endmodule

// ==== sim.f ====
logic/fetch_pkg.sv
logic/pc_select.sv
logic/instr_scan.sv
logic/branch_history.sv
logic/return_stack.sv
logic/branch_predict.sv
logic/fetch_queue.sv
logic/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

// ==== testbench/tb_fetch_frontend.sv ====
// fetch frontend testbench
// program memory behind a one-cycle cache model, directed tests that compare
// the acknowledged entry stream with the sequence the prediction rules give
module tb_fetch_frontend import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic              clk_i;
    logic              rst_ni;
    logic              flush_i;
    logic [ADDR_W-1:0] boot_addr_i;
    resolved_t         resolved_i;
    redirect_t         redirect_i;
    icache_req_t       icache_req_o;
    icache_rsp_t       icache_rsp_i;
    fetch_entry_t      fetch_entry_o;
    logic              fetch_valid_o;
    logic              fetch_ack_i;

    // 4 KB of program, everything above reads the fill pattern
    logic [INSTR_W-1:0] prog_mem [1024];
    icache_req_t        req_seen;
    logic [31:0]        rng_state;
    int                 mismatch_count;
    int                 other_count;

    // acknowledged entries and the expected stream
    logic [ADDR_W-1:0]  got_addr_q [$];
    logic               got_taken_q [$];
    logic [INSTR_W-1:0] got_instr_q [$];
    logic [ADDR_W-1:0]  got_pred_q [$];
    logic [ADDR_W-1:0]  exp_addr_q [$];
    logic               exp_taken_q [$];

    fetch_frontend dut (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_i       ( flush_i       ),
        .boot_addr_i   ( boot_addr_i   ),
        .resolved_i    ( resolved_i    ),
        .redirect_i    ( redirect_i    ),
        .icache_req_o  ( icache_req_o  ),
        .icache_rsp_i  ( icache_rsp_i  ),
        .fetch_entry_o ( fetch_entry_o ),
        .fetch_valid_o ( fetch_valid_o ),
        .fetch_ack_i   ( fetch_ack_i   )
    );

    always #5 clk_i = ~clk_i;

    // --------------------------------------------------
    // program memory and cache model
    // --------------------------------------------------
    // OP-IMM opcode keeps every fill word free of control flow
    function automatic logic [INSTR_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return ((addr * 32'h9e3779b1) & 32'hffff_ff80) | 32'h0000_0013;
    endfunction

    function automatic logic [INSTR_W-1:0] fetch_word(input logic [ADDR_W-1:0] addr);
        if (addr[ADDR_W-1:12] == '0) begin
            return prog_mem[addr[11:2]];
        end
        return fill_word(addr);
    endfunction

    task automatic clear_program();
        for (int i = 0; i < 1024; i++) begin
            prog_mem[i] = fill_word(ADDR_W'(i * 4));
        end
    endtask

    task automatic put(input logic [ADDR_W-1:0] addr, input logic [INSTR_W-1:0] word);
        prog_mem[addr[11:2]] = word;
    endtask

    // request sampled mid cycle, answered in the next cycle
    always begin
        @(negedge clk_i);
        req_seen = icache_req_o;
        @(posedge clk_i);
        #1;
        icache_rsp_i.valid = req_seen.req;
        icache_rsp_i.vaddr = req_seen.vaddr;
        icache_rsp_i.data  = fetch_word(req_seen.vaddr);
    end

    // --------------------------------------------------
    // instruction encoders and random source
    // --------------------------------------------------
    // beq x0, x0, off
    function automatic logic [INSTR_W-1:0] enc_branch(input int off);
        logic [12:0] imm;
        imm = off[12:0];
        return {imm[12], imm[10:5], 5'd0, 5'd0, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [INSTR_W-1:0] enc_jal(input logic [4:0] rd, input int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [INSTR_W-1:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'd0, rs1, 3'b000, rd, OPC_JALR};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // --------------------------------------------------
    // drive and check helpers
    // --------------------------------------------------
    task automatic reset_dut(input logic [ADDR_W-1:0] boot);
        @(posedge clk_i);
        #1;
        rst_ni      = 1'b0;
        boot_addr_i = boot;
        fetch_ack_i = 1'b0;
        flush_i     = 1'b0;
        resolved_i  = '0;
        redirect_i  = '0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
    endtask

    // one cycle of backend input, decode stalled meanwhile
    task automatic pulse_backend(input redirect_t rd, input resolved_t rs);
        @(posedge clk_i);
        #1;
        fetch_ack_i = 1'b0;
        redirect_i  = rd;
        resolved_i  = rs;
        @(posedge clk_i);
        #1;
        redirect_i = '0;
        resolved_i = '0;
    endtask

    task automatic expect_entry(input logic [ADDR_W-1:0] addr, input logic taken);
        exp_addr_q.push_back(addr);
        exp_taken_q.push_back(taken);
    endtask

    // straight line code, nothing predicted taken
    task automatic expect_run(input logic [ADDR_W-1:0] start, input int n);
        for (int i = 0; i < n; i++) begin
            expect_entry(start + ADDR_W'(4 * i), 1'b0);
        end
    endtask

    // an entry counts once it is shown with ack high, it leaves at the next edge
    task automatic collect(input int n, input logic random_ack);
        int idle;
        idle = 0;
        while (got_addr_q.size() < n && idle < 200) begin
            @(posedge clk_i);
            #1;
            if (random_ack) begin
                rng_state   = lcg_next(rng_state);
                fetch_ack_i = rng_state[20];
            end else begin
                fetch_ack_i = 1'b1;
            end
            if (fetch_ack_i && fetch_valid_o) begin
                got_addr_q.push_back(fetch_entry_o.addr);
                got_taken_q.push_back(fetch_entry_o.taken);
                got_instr_q.push_back(fetch_entry_o.instr);
                got_pred_q.push_back(fetch_entry_o.predict_address);
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got_addr_q.size() < n) begin
            $display("timeout at %0t: no fetch entry for 200 cycles", $time);
            other_count++;
        end
    endtask

    task automatic compare(input string name);
        if (got_addr_q.size() != exp_addr_q.size()) begin
            $display("%s: got %0d entries where %0d were expected", name,
                     got_addr_q.size(), exp_addr_q.size());
            other_count++;
        end
        for (int i = 0; i < exp_addr_q.size() && i < got_addr_q.size(); i++) begin
            if (got_addr_q[i] !== exp_addr_q[i]) begin
                $display("mismatch at %0t: %s entry %0d addr %h, expected %h", $time,
                         name, i, got_addr_q[i], exp_addr_q[i]);
                mismatch_count++;
            end
            if (got_taken_q[i] !== exp_taken_q[i]) begin
                $display("mismatch at %0t: %s entry %0d taken %0b, expected %0b", $time,
                         name, i, got_taken_q[i], exp_taken_q[i]);
                mismatch_count++;
            end
            if (got_instr_q[i] !== fetch_word(exp_addr_q[i])) begin
                $display("mismatch at %0t: %s entry %0d instr %h, expected %h", $time,
                         name, i, got_instr_q[i], fetch_word(exp_addr_q[i]));
                mismatch_count++;
            end
            // a taken entry points at the entry that follows it
            if (exp_taken_q[i] && i + 1 < exp_addr_q.size()
                    && got_pred_q[i] !== exp_addr_q[i+1]) begin
                $display("mismatch at %0t: %s entry %0d target %h, expected %h", $time,
                         name, i, got_pred_q[i], exp_addr_q[i+1]);
                mismatch_count++;
            end
        end
        got_addr_q.delete();
        got_taken_q.delete();
        got_instr_q.delete();
        got_pred_q.delete();
        exp_addr_q.delete();
        exp_taken_q.delete();
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_boot();
        clear_program();
        reset_dut(32'h100);
        expect_run(32'h100, 3);
        collect(3, 1'b0);
        compare("boot");
    endtask

    // untrained table, backward taken and forward not taken
    task automatic test_static_predict();
        clear_program();
        put(32'h204, enc_branch(12));
        put(32'h20c, enc_branch(-8));
        reset_dut(32'h200);
        expect_run(32'h200, 3);
        expect_entry(32'h20c, 1'b1);
        expect_run(32'h204, 2);
        collect(6, 1'b0);
        compare("static prediction");
    endtask

    task automatic test_call_return();
        clear_program();
        put(32'h300, enc_jal(REG_RA, 32'h40));
        put(32'h344, enc_jalr(5'd0, REG_RA));
        reset_dut(32'h300);
        expect_entry(32'h300, 1'b1);
        expect_entry(32'h340, 1'b0);
        expect_entry(32'h344, 1'b1);
        // return lands on the word after the call
        expect_run(32'h304, 2);
        collect(5, 1'b0);
        compare("call and return");
    endtask

    task automatic test_counter_training();
        resolved_t rs;
        clear_program();
        put(32'h414, enc_branch(-20));
        reset_dut(32'h400);
        rs          = '0;
        rs.valid    = 1'b1;
        rs.pc       = 32'h414;
        rs.target   = 32'h418;
        // both resolutions land before the branch word comes back
        pulse_backend('0, rs);
        pulse_backend('0, rs);
        expect_run(32'h400, 8);
        collect(8, 1'b0);
        compare("counter training");
    endtask

    // loop with a call, a forward branch, a return and a backward branch
    task automatic test_back_pressure();
        logic [ADDR_W-1:0] loop_addr [9];
        logic [8:0]        loop_taken;
        loop_addr  = '{32'h500, 32'h504, 32'h508, 32'h540, 32'h544,
                       32'h548, 32'h54c, 32'h50c, 32'h510};
        loop_taken = 9'b1_0100_0100;
        clear_program();
        put(32'h508, enc_jal(REG_RA, 32'h38));
        put(32'h544, enc_branch(8));
        put(32'h54c, enc_jalr(5'd0, REG_RA));
        put(32'h510, enc_branch(-16));
        for (int pass = 0; pass < 2; pass++) begin
            reset_dut(32'h500);
            for (int i = 0; i < 20; i++) begin
                expect_entry(loop_addr[i % 9], loop_taken[i % 9]);
            end
            collect(20, pass == 1);
            compare(pass == 1 ? "random ack" : "steady ack");
        end
    endtask

    task automatic test_redirect_priority();
        redirect_t rd;
        resolved_t rs;
        clear_program();
        reset_dut(32'h600);
        expect_run(32'h600, 3);
        collect(3, 1'b0);
        compare("before redirect");
        // trap outranks eret
        rd             = '0;
        rs             = '0;
        rd.ex_valid    = 1'b1;
        rd.trap_vector = 32'h700;
        rd.eret        = 1'b1;
        rd.epc         = 32'h780;
        pulse_backend(rd, rs);
        expect_run(32'h700, 2);
        collect(2, 1'b0);
        compare("trap over eret");
        rd               = '0;
        rd.set_pc_commit = 1'b1;
        rd.pc_commit     = 32'h7f0;
        pulse_backend(rd, rs);
        expect_run(32'h7f4, 2);
        collect(2, 1'b0);
        compare("commit restart");
        rd               = '0;
        rs.valid         = 1'b1;
        rs.is_mispredict = 1'b1;
        rs.pc            = 32'h7a0;
        rs.target        = 32'h740;
        pulse_backend(rd, rs);
        expect_run(32'h740, 2);
        collect(2, 1'b0);
        compare("mispredict");
    endtask

    initial begin
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        boot_addr_i    = '0;
        resolved_i     = '0;
        redirect_i     = '0;
        icache_rsp_i   = '0;
        fetch_ack_i    = 1'b0;
        mismatch_count = 0;
        other_count    = 0;
        rng_state      = 32'h35640cf2;
        test_boot();
        test_static_predict();
        test_call_return();
        test_counter_training();
        test_back_pressure();
        test_redirect_priority();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
